/* build.f */
logic/mmm_pkg.sv
logic/mul_90b.sv
logic/kara3_product.sv
logic/kara3_low_product.sv
logic/mmm_nlp_top.sv
tb/mmm_nlp_asserts.sv
tb/mmm_nlp_tb.sv

/* Bender.yml */
package:
  name: mmm_nlp

sources:
  # design
  - files:
      - logic/mmm_pkg.sv
      - logic/mul_90b.sv
      - logic/kara3_product.sv
      - logic/kara3_low_product.sv
      - logic/mmm_nlp_top.sv
  # verification
  - target: test
    files:
      - tb/mmm_nlp_asserts.sv
      - tb/mmm_nlp_tb.sv

/* tb/mmm_nlp_tb.sv */
// table-driven testbench for mmm_nlp_top
// reference product and quotient, result queue, watchdog and summary
module mmm_nlp_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 5;
    localparam int SEED          = 56;
    localparam int NUM_FIXED     = 10;
    localparam int NUM_RAND      = 30;
    localparam int NUM_ENTRIES   = NUM_FIXED + NUM_RAND;
    localparam int WATCHDOG_CYC  = NUM_ENTRIES + mmm_pkg::TOTAL_LAT + 10 + 5;

    typedef logic [mmm_pkg::OP_W-1:0] op_t;

    typedef struct packed {
        logic           valid;
        op_t            a;
        op_t            b;
        op_t            m_b;
        mmm_pkg::prod_t prod;
        mmm_pkg::low_t  q;
    } entry_t;

    typedef struct packed {
        mmm_pkg::prod_t prod;
        mmm_pkg::low_t  q;
        int unsigned    issue_cyc;
    } expect_t;

    logic           i_clk;
    logic           i_rstn;
    logic           i_valid;
    op_t            i_a;
    op_t            i_b;
    op_t            i_m_b;
    logic           o_valid;
    mmm_pkg::prod_t o_prod;
    mmm_pkg::low_t  o_q;

    entry_t         table_q [NUM_ENTRIES];
    expect_t        pending [$];
    expect_t        cur;
    mmm_pkg::prod_t last_prod = '0;
    mmm_pkg::low_t  last_q = '0;
    int unsigned    cyc = 0;
    logic           mon_en = 1'b0;
    int             prod_errs = 0;
    int             q_errs = 0;
    int             vld_errs = 0;
    int             other_errs = 0;

    mmm_nlp_top i_dut (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_valid (i_valid),
        .i_a     (i_a),
        .i_b     (i_b),
        .i_m_b   (i_m_b),
        .o_valid (o_valid),
        .o_prod  (o_prod),
        .o_q     (o_q)
    );

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic mmm_pkg::prod_t ref_prod(input op_t a, input op_t b);
        mmm_pkg::prod_t wa;
        mmm_pkg::prod_t wb;
        wa = mmm_pkg::prod_t'(a);
        wb = mmm_pkg::prod_t'(b);
        return wa * wb;
    endfunction

    // q = (T mod 2^261) * m' mod 2^261
    function automatic mmm_pkg::low_t ref_quot(input mmm_pkg::prod_t t, input op_t mb);
        logic [2*mmm_pkg::LOW_W-1:0] u;
        logic [2*mmm_pkg::LOW_W-1:0] m;
        logic [2*mmm_pkg::LOW_W-1:0] full;
        u    = {{mmm_pkg::LOW_W{1'b0}}, t[mmm_pkg::LOW_W-1:0]};
        m    = {{(2*mmm_pkg::LOW_W - mmm_pkg::OP_W){1'b0}}, mb};
        full = u * m;
        return full[mmm_pkg::LOW_W-1:0];
    endfunction

    function automatic op_t rand_op();
        op_t r;
        r = '0;
        for (int k = 0; k < mmm_pkg::OP_W / 32; k++) begin
            r = {r[mmm_pkg::OP_W-33:0], 32'($urandom)};
        end
        return r;
    endfunction

    task automatic fill_entry(input int idx, input logic vld, input op_t a, input op_t b,
                              input op_t mb);
        table_q[idx].valid = vld;
        table_q[idx].a     = a;
        table_q[idx].b     = b;
        table_q[idx].m_b   = mb;
        table_q[idx].prod  = ref_prod(a, b);
        table_q[idx].q     = ref_quot(table_q[idx].prod, mb);
    endtask

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic check_prod(input mmm_pkg::prod_t got, input mmm_pkg::prod_t exp);
        if (got !== exp) begin
            prod_errs++;
            $display("** Error: o_prod = %h, expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_q(input mmm_pkg::low_t got, input mmm_pkg::low_t exp);
        if (got !== exp) begin
            q_errs++;
            $display("** Error: o_q = %h, expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            vld_errs++;
            $display("** Error: o_valid = %h, expected %h at %0t", got, exp, $time);
        end
    endtask

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
    end

    // outputs are sampled mid-cycle away from the rising edge
    always @(negedge i_clk) begin
        if (mon_en) begin
            if (!i_rstn) begin
                check_valid(o_valid, 1'b0);
                check_prod(o_prod, '0);
                check_q(o_q, '0);
            end else if (o_valid) begin
                if (pending.size() == 0) begin
                    other_errs++;
                    $display("o_valid pulse at %0t with no operation in flight", $time);
                end else begin
                    cur = pending.pop_front();
                    if (cyc - cur.issue_cyc != mmm_pkg::TOTAL_LAT) begin
                        other_errs++;
                        $display("result arrived %0d cycles after issue instead of %0d",
                                 cyc - cur.issue_cyc, mmm_pkg::TOTAL_LAT);
                    end
                    check_prod(o_prod, cur.prod);
                    check_q(o_q, cur.q);
                    last_prod = cur.prod;
                    last_q    = cur.q;
                end
            end else begin
                // outputs hold the last result or zero before the first one
                check_prod(o_prod, last_prod);
                check_q(o_q, last_q);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYC);
        $display("SIMULATION FAILED");
        $finish;
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial begin
        i_rstn  = 1'b0;
        i_valid = 1'b0;
        i_a     = '0;
        i_b     = '0;
        i_m_b   = '0;
        void'($urandom(SEED));

        // zeros, ones, all-ones and limb boundaries
        fill_entry(0, 1'b1, '0, '0, '0);
        fill_entry(1, 1'b1, op_t'(1), op_t'(1), op_t'(1));
        fill_entry(2, 1'b1, '1, '1, '1);
        fill_entry(3, 1'b1, (op_t'(1) << 87) - 1, (op_t'(1) << 87) - 1, '1);
        fill_entry(4, 1'b1, op_t'(1) << 87, op_t'(1) << 174, (op_t'(1) << 87) - 1);
        fill_entry(5, 1'b1, op_t'(1) << 174, op_t'(1) << 174, op_t'(1));
        fill_entry(6, 1'b0, '1, op_t'(1) << 87, '1);
        fill_entry(7, 1'b1, (op_t'(1) << 174) - 1, '1, '1);
        fill_entry(8, 1'b1, '1, op_t'(1) << 87, (op_t'(1) << 174) + 1);
        fill_entry(9, 1'b1, ~(op_t'(1) << 174), (op_t'(1) << 87) - 1, '1);
        // random operands with about one gap in five
        for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
            fill_entry(i, ($urandom % 5) != 0, rand_op(), rand_op(), rand_op());
        end

        @(posedge i_clk);
        mon_en = 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge i_clk);
        @(negedge i_clk);
        i_rstn = 1'b1;
        repeat (2) @(negedge i_clk);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(negedge i_clk);
            i_valid = table_q[i].valid;
            i_a     = table_q[i].a;
            i_b     = table_q[i].b;
            i_m_b   = table_q[i].m_b;
            if (table_q[i].valid) begin
                pending.push_back('{prod: table_q[i].prod, q: table_q[i].q, issue_cyc: cyc});
            end
        end
        @(negedge i_clk);
        i_valid = 1'b0;
        repeat (mmm_pkg::TOTAL_LAT + 2) @(negedge i_clk);

        if (pending.size() != 0) begin
            other_errs += pending.size();
            $display("%0d expected result(s) never arrived on o_valid", pending.size());
        end

        $display("errors: o_prod %0d, o_q %0d, o_valid %0d, other %0d, assertions %0d",
                 prod_errs, q_errs, vld_errs, other_errs, i_dut.i_asserts.fail_count);
        if (prod_errs + q_errs + vld_errs + other_errs
            + i_dut.i_asserts.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tb/mmm_nlp_asserts.sv */
// concurrent checks on the NLP Montgomery front end bound to mmm_nlp_top
// latency of o_valid, quiet outputs in reset, known data with o_valid
module mmm_nlp_asserts (
    input logic                 i_clk,
    input logic                 i_rstn,
    input logic                 i_valid,
    input logic                 i_out_valid,
    input mmm_pkg::prod_t       i_prod,
    input mmm_pkg::low_t        i_q
);

    int          fail_count = 0;
    // clock ticks seen so far, up to the depth of the latency history
    int unsigned ticks = 0;

    always @(posedge i_clk) begin
        if (ticks < mmm_pkg::TOTAL_LAT) begin
            ticks <= ticks + 1;
        end
    end

    // every operation leaves exactly TOTAL_LAT cycles after it entered
    a_latency: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        (ticks >= mmm_pkg::TOTAL_LAT) |-> i_out_valid == $past(i_valid, mmm_pkg::TOTAL_LAT)
    ) else begin
        fail_count++;
        $error("o_valid does not follow i_valid by %0d cycles", mmm_pkg::TOTAL_LAT);
    end

    a_reset_quiet: assert property (
        @(posedge i_clk) !i_rstn |-> !i_out_valid
    ) else begin
        fail_count++;
        $error("o_valid high while reset is active");
    end

    a_known_data: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        i_out_valid |-> !$isunknown({i_prod, i_q})
    ) else begin
        fail_count++;
        $error("o_prod or o_q unknown while o_valid is high");
    end

endmodule

bind mmm_nlp_top mmm_nlp_asserts i_asserts (
    .i_clk       (i_clk),
    .i_rstn      (i_rstn),
    .i_valid     (i_valid),
    .i_out_valid (o_valid),
    .i_prod      (o_prod),
    .i_q         (o_q)
);

/* logic/mmm_nlp_top.sv */
// NLP Montgomery front end: full product T and quotient q
// two Karatsuba steps with m' and product alignment delays
module mmm_nlp_top (
    input  logic                     i_clk,
    input  logic                     i_rstn,
    input  logic                     i_valid,
    input  logic [mmm_pkg::OP_W-1:0] i_a,
    input  logic [mmm_pkg::OP_W-1:0] i_b,
    input  logic [mmm_pkg::OP_W-1:0] i_m_b,
    output logic                     o_valid,
    output mmm_pkg::prod_t           o_prod,
    output mmm_pkg::low_t            o_q
);

    mmm_pkg::operand_u a_w;
    mmm_pkg::operand_u b_w;
    mmm_pkg::operand_u mb_w;
    mmm_pkg::operand_u u_w;
    logic              s1_valid;
    mmm_pkg::prod_t    s1_prod;
    logic              s2_valid;

    // m' waits for step 1
    mmm_pkg::operand_u mb_dly [mmm_pkg::STEP_LAT];
    // product waits for step 2, last stage is o_prod
    mmm_pkg::prod_t    prod_dly [mmm_pkg::STEP_LAT-1];
    logic [mmm_pkg::STEP_LAT-2:0] vld_dly;

    assign a_w.flat  = {{(mmm_pkg::LOW_W - mmm_pkg::OP_W){1'b0}}, i_a};
    assign b_w.flat  = {{(mmm_pkg::LOW_W - mmm_pkg::OP_W){1'b0}}, i_b};
    assign mb_w.flat = {{(mmm_pkg::LOW_W - mmm_pkg::OP_W){1'b0}}, i_m_b};

    kara3_product i_step1 (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_valid (i_valid),
        .i_a     (a_w),
        .i_b     (b_w),
        .o_valid (s1_valid),
        .o_prod  (s1_prod)
    );

    // u is the low three limbs of T
    assign u_w.flat = s1_prod[mmm_pkg::LOW_W-1:0];

    kara3_low_product i_step2 (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_valid (s1_valid),
        .i_u     (u_w),
        .i_m_b   (mb_dly[mmm_pkg::STEP_LAT-1]),
        .o_valid (s2_valid),
        .o_q     (o_q)
    );

    ////////////////////////////////
    // alignment delays
    ////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            vld_dly <= '0;
            o_prod  <= '0;
            for (int i = 0; i < mmm_pkg::STEP_LAT; i++) begin
                mb_dly[i] <= '0;
            end
            for (int i = 0; i < mmm_pkg::STEP_LAT - 1; i++) begin
                prod_dly[i] <= '0;
            end
        end else begin
            mb_dly[0]   <= mb_w;
            prod_dly[0] <= s1_prod;
            vld_dly     <= {vld_dly[mmm_pkg::STEP_LAT-3:0], s1_valid};
            for (int i = 1; i < mmm_pkg::STEP_LAT; i++) begin
                mb_dly[i] <= mb_dly[i-1];
            end
            for (int i = 1; i < mmm_pkg::STEP_LAT - 1; i++) begin
                prod_dly[i] <= prod_dly[i-1];
            end
            // lands in the same cycle as step 2's quotient
            if (vld_dly[mmm_pkg::STEP_LAT-2]) begin
                o_prod <= prod_dly[mmm_pkg::STEP_LAT-2];
            end
        end
    end

    assign o_valid = s2_valid;

endmodule

/* logic/kara3_low_product.sv */
// step 2: low 261 bits of u times m', the Montgomery quotient
// five limb multiplies, limb offsets 0 to 2 only
module kara3_low_product (
    input  logic              i_clk,
    input  logic              i_rstn,
    input  logic              i_valid,
    input  mmm_pkg::operand_u i_u,
    input  mmm_pkg::operand_u i_m_b,
    output logic              o_valid,
    output mmm_pkg::low_t     o_q
);

    logic [mmm_pkg::MUL_LAT:0] vld_sr;
    mmm_pkg::mul_res_t         res [5];
    mmm_pkg::low_t             cross1;
    mmm_pkg::low_t             diag2;
    mmm_pkg::low_t             q_d;

    // u side: u0, u1, u0+u1, u0, u2
    function automatic mmm_pkg::mul_in_t u_term(mmm_pkg::limbs_t x, int unsigned idx);
        mmm_pkg::mul_in_t lo;
        mmm_pkg::mul_in_t mid;
        lo  = mmm_pkg::mul_in_t'(x.lo);
        mid = mmm_pkg::mul_in_t'(x.mid);
        case (idx)
            1:       return mid;
            2:       return lo + mid;
            4:       return mmm_pkg::mul_in_t'(x.hi);
            default: return lo;
        endcase
    endfunction

    // m' side: m0, m1, m0+m1, m2, m0
    function automatic mmm_pkg::mul_in_t m_term(mmm_pkg::limbs_t x, int unsigned idx);
        mmm_pkg::mul_in_t lo;
        mmm_pkg::mul_in_t mid;
        lo  = mmm_pkg::mul_in_t'(x.lo);
        mid = mmm_pkg::mul_in_t'(x.mid);
        case (idx)
            1:       return mid;
            2:       return lo + mid;
            3:       return mmm_pkg::mul_in_t'(x.hi);
            default: return lo;
        endcase
    endfunction

    for (genvar k = 0; k < 5; k++) begin : g_term
        mmm_pkg::mul_in_t op_u_q;
        mmm_pkg::mul_in_t op_m_q;

        always_ff @(posedge i_clk or negedge i_rstn) begin
            if (!i_rstn) begin
                op_u_q <= '0;
                op_m_q <= '0;
            end else begin
                op_u_q <= u_term(i_u.limbs, k);
                op_m_q <= m_term(i_m_b.limbs, k);
            end
        end

        mul_90b i_mul (
            .i_clk  (i_clk),
            .i_rstn (i_rstn),
            .i_a    (op_u_q),
            .i_b    (op_m_q),
            .o_res  (res[k])
        );
    end

    ////////////////////////////////
    // truncated recombination
    ////////////////////////////////
    // everything wraps modulo 2^261
    always_comb begin
        cross1 = mmm_pkg::low_t'(res[2]) - mmm_pkg::low_t'(res[0]) - mmm_pkg::low_t'(res[1]);
        diag2  = mmm_pkg::low_t'(res[3]) + mmm_pkg::low_t'(res[4]) + mmm_pkg::low_t'(res[1]);
        q_d    = mmm_pkg::low_t'(res[0])
               + (cross1 << mmm_pkg::LIMB_W)
               + (diag2 << (2 * mmm_pkg::LIMB_W));
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            vld_sr  <= '0;
            o_valid <= 1'b0;
            o_q     <= '0;
        end else begin
            vld_sr  <= {vld_sr[mmm_pkg::MUL_LAT-1:0], i_valid};
            o_valid <= vld_sr[mmm_pkg::MUL_LAT];
            if (vld_sr[mmm_pkg::MUL_LAT]) begin
                o_q <= q_d;
            end
        end
    end

endmodule

/* logic/kara3_product.sv */
// step 1: three-way Karatsuba full product of two 256-bit operands
// limb pre-add register, six pipelined multipliers, recombination register
module kara3_product (
    input  logic              i_clk,
    input  logic              i_rstn,
    input  logic              i_valid,
    input  mmm_pkg::operand_u i_a,
    input  mmm_pkg::operand_u i_b,
    output logic              o_valid,
    output mmm_pkg::prod_t    o_prod
);

    // valid beside pre-add and multiplier stages
    logic [mmm_pkg::MUL_LAT:0] vld_sr;
    mmm_pkg::mul_res_t         res [6];
    mmm_pkg::kara_res_t        kr;
    mmm_pkg::prod_t            mid1;
    mmm_pkg::prod_t            mid2;
    mmm_pkg::prod_t            mid3;
    mmm_pkg::prod_t            prod_d;

    // term order matches kara_res_t: lo, mid, hi, lo+mid, lo+hi, mid+hi
    function automatic mmm_pkg::mul_in_t term_of(mmm_pkg::limbs_t x, int unsigned idx);
        mmm_pkg::mul_in_t lo;
        mmm_pkg::mul_in_t mid;
        mmm_pkg::mul_in_t hi;
        lo  = mmm_pkg::mul_in_t'(x.lo);
        mid = mmm_pkg::mul_in_t'(x.mid);
        hi  = mmm_pkg::mul_in_t'(x.hi);
        case (idx)
            0:       return lo;
            1:       return mid;
            2:       return hi;
            3:       return lo + mid;
            4:       return lo + hi;
            default: return mid + hi;
        endcase
    endfunction

    ////////////////////////////////
    // pre-add and multiply
    ////////////////////////////////
    for (genvar k = 0; k < 6; k++) begin : g_term
        mmm_pkg::mul_in_t op_a_q;
        mmm_pkg::mul_in_t op_b_q;

        always_ff @(posedge i_clk or negedge i_rstn) begin
            if (!i_rstn) begin
                op_a_q <= '0;
                op_b_q <= '0;
            end else begin
                op_a_q <= term_of(i_a.limbs, k);
                op_b_q <= term_of(i_b.limbs, k);
            end
        end

        mul_90b i_mul (
            .i_clk  (i_clk),
            .i_rstn (i_rstn),
            .i_a    (op_a_q),
            .i_b    (op_b_q),
            .o_res  (res[k])
        );
    end

    assign kr = '{p0: res[0], p1: res[1], p2: res[2], p01: res[3], p02: res[4], p12: res[5]};

    ////////////////////////////////
    // recombination
    ////////////////////////////////
    // cross terms: pair product minus diagonals, p1 returns in the middle limb
    always_comb begin
        mid1 = mmm_pkg::prod_t'(kr.p01) - mmm_pkg::prod_t'(kr.p0) - mmm_pkg::prod_t'(kr.p1);
        mid2 = mmm_pkg::prod_t'(kr.p02) - mmm_pkg::prod_t'(kr.p0) - mmm_pkg::prod_t'(kr.p2)
             + mmm_pkg::prod_t'(kr.p1);
        mid3 = mmm_pkg::prod_t'(kr.p12) - mmm_pkg::prod_t'(kr.p1) - mmm_pkg::prod_t'(kr.p2);
        prod_d = mmm_pkg::prod_t'(kr.p0)
               + (mid1 << mmm_pkg::LIMB_W)
               + (mid2 << (2 * mmm_pkg::LIMB_W))
               + (mid3 << (3 * mmm_pkg::LIMB_W))
               + (mmm_pkg::prod_t'(kr.p2) << (4 * mmm_pkg::LIMB_W));
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            vld_sr  <= '0;
            o_valid <= 1'b0;
            o_prod  <= '0;
        end else begin
            vld_sr  <= {vld_sr[mmm_pkg::MUL_LAT-1:0], i_valid};
            o_valid <= vld_sr[mmm_pkg::MUL_LAT];
            // hold the last product between operations
            if (vld_sr[mmm_pkg::MUL_LAT]) begin
                o_prod <= prod_d;
            end
        end
    end

endmodule

/* logic/mul_90b.sv */
// three-stage pipelined 90x90 unsigned multiplier
// b times 24-bit slices of a, shifted partial sums in the last stage
module mul_90b (
    input  logic              i_clk,
    input  logic              i_rstn,
    input  mmm_pkg::mul_in_t  i_a,
    input  mmm_pkg::mul_in_t  i_b,
    output mmm_pkg::mul_res_t o_res
);

    mmm_pkg::mul_in_t  a_q;
    mmm_pkg::mul_in_t  b_q;
    // a padded up to a whole number of slices
    logic [mmm_pkg::NUM_SLICES*mmm_pkg::SLICE_W-1:0] a_ext;
    logic [mmm_pkg::SLICE_W+mmm_pkg::MUL_W-1:0]      pp_q [mmm_pkg::NUM_SLICES];
    mmm_pkg::mul_res_t sum_d;

    assign a_ext = {{(mmm_pkg::NUM_SLICES*mmm_pkg::SLICE_W - mmm_pkg::MUL_W){1'b0}}, a_q};

    // stage 1 operand register, stage 2 partial products
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            a_q <= '0;
            b_q <= '0;
            for (int k = 0; k < mmm_pkg::NUM_SLICES; k++) begin
                pp_q[k] <= '0;
            end
        end else begin
            a_q <= i_a;
            b_q <= i_b;
            for (int k = 0; k < mmm_pkg::NUM_SLICES; k++) begin
                pp_q[k] <= a_ext[k*mmm_pkg::SLICE_W +: mmm_pkg::SLICE_W] * b_q;
            end
        end
    end

    // top slice is only 18 bits wide, so the sum never overflows 181 bits
    always_comb begin
        sum_d = '0;
        for (int k = 0; k < mmm_pkg::NUM_SLICES; k++) begin
            sum_d = sum_d + (mmm_pkg::mul_res_t'(pp_q[k]) << (k * mmm_pkg::SLICE_W));
        end
    end

    // stage 3 result
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_res <= '0;
        end else begin
            o_res <= sum_d;
        end
    end

endmodule

/* logic/mmm_pkg.sv */
// widths, latencies and limb types for the NLP Montgomery front end
// operand union and the Karatsuba limb-product struct
package mmm_pkg;

    ////////////////////////////////
    // widths
    ////////////////////////////////
    localparam int LIMB_W    = 87;
    localparam int NUM_LIMBS = 3;
    localparam int OP_W      = 256;
    // three limbs, also the modulus of the quotient
    localparam int LOW_W     = NUM_LIMBS * LIMB_W;
    // limb plus pre-add carry, with spare bits
    localparam int MUL_W     = 90;
    localparam int MUL_RES_W = 181;
    // six limbs
    localparam int PROD_W    = 2 * NUM_LIMBS * LIMB_W;

    // multiplier a input is cut into slices of this width
    localparam int SLICE_W    = 24;
    localparam int NUM_SLICES = (MUL_W + SLICE_W - 1) / SLICE_W;

    ////////////////////////////////
    // latencies
    ////////////////////////////////
    localparam int MUL_LAT   = 3;
    // pre-add register, multiplier, recombination register
    localparam int STEP_LAT  = MUL_LAT + 2;
    // step 1 then step 2
    localparam int TOTAL_LAT = 2 * STEP_LAT;

    ////////////////////////////////
    // types
    ////////////////////////////////
    typedef logic [LIMB_W-1:0] limb_t;

    typedef struct packed {
        limb_t hi;
        limb_t mid;
        limb_t lo;
    } limbs_t;

    // operand zero-extended from OP_W to three full limbs
    typedef union packed {
        logic [LOW_W-1:0] flat;
        limbs_t           limbs;
    } operand_u;

    typedef logic [MUL_W-1:0]     mul_in_t;
    typedef logic [MUL_RES_W-1:0] mul_res_t;
    typedef logic [PROD_W-1:0]    prod_t;
    typedef logic [LOW_W-1:0]     low_t;

    // step 1 multiplier results, diagonal terms then pair sums
    typedef struct packed {
        mul_res_t p0;
        mul_res_t p1;
        mul_res_t p2;
        mul_res_t p01;
        mul_res_t p02;
        mul_res_t p12;
    } kara_res_t;

endpackage
